// File: core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;      // Data, address or instruction
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;   // SRAM byte write enables

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_addi,
        op_lu12i,
        op_ld,
        op_st,
        op_beq,
        op_bne,
        op_rdcnt
    } op_t;

    localparam word_t reset_pc = 32'h1c00_0000;

    // Three-register format, matched on inst[31:15]
    localparam logic [16:0] opc_add_w     = 17'h00020;
    localparam logic [16:0] opc_sub_w     = 17'h00022;

    // 12-bit immediate format, matched on inst[31:22]
    localparam logic [9:0]  opc_addi_w    = 10'h00a;
    localparam logic [9:0]  opc_ld_w      = 10'h0a2;
    localparam logic [9:0]  opc_st_w      = 10'h0a6;

    localparam logic [6:0]  opc_lu12i_w   = 7'h0a;         // inst[31:25]

    // Branches with 16-bit offset, matched on inst[31:26]
    localparam logic [5:0]  opc_beq       = 6'h16;
    localparam logic [5:0]  opc_bne       = 6'h17;

    // Matched on inst[31:5] with rj zero
    localparam logic [26:0] opc_rdcntvl_w = 27'h0000300;

endpackage

`default_nettype wire

// File: regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire core_pkg::reg_idx_t  raddr1,
    input  wire core_pkg::reg_idx_t  raddr2,
    output core_pkg::word_t          rdata1,
    output core_pkg::word_t          rdata2,
    input  wire                      we,
    input  wire core_pkg::reg_idx_t  waddr,
    input  wire core_pkg::word_t     wdata
);
    import core_pkg::*;

    word_t regs [1:31];

    // No bypass of a same-cycle write
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: if_stage.sv
`timescale 1ns/100ps
`default_nettype none

module if_stage (
    input  wire                    clk,
    input  wire                    arst_n,
    output logic                   inst_sram_en,
    output core_pkg::byte_en_t     inst_sram_we,
    output core_pkg::word_t        inst_sram_addr,
    output core_pkg::word_t        inst_sram_wdata,
    input  wire core_pkg::word_t   inst_sram_rdata,
    input  wire                    id_allowin,
    input  wire                    br_taken,
    input  wire core_pkg::word_t   br_target,
    output logic                   if_to_id_valid,
    output core_pkg::word_t        if_pc,
    output core_pkg::word_t        if_inst
);
    import core_pkg::*;

    logic  started;      // Set on the first edge after reset
    logic  req_pend;     // SRAM word for pc arrives this cycle
    logic  buf_valid;
    logic  full;
    word_t inst_buf;
    word_t pc;
    word_t next_pc;

    assign full    = req_pend | buf_valid;
    assign next_pc = br_taken ? br_target : (full ? pc + 32'd4 : pc);

    assign inst_sram_en    = started & (~full | id_allowin);
    assign inst_sram_we    = '0;
    assign inst_sram_addr  = next_pc;
    assign inst_sram_wdata = '0;

    assign if_to_id_valid = full & ~br_taken;    // Wrong-path word dropped
    assign if_pc          = pc;
    assign if_inst        = buf_valid ? inst_buf : inst_sram_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started   <= 1'b0;
            req_pend  <= 1'b0;
            buf_valid <= 1'b0;
            pc        <= reset_pc;
        end else begin
            started <= 1'b1;
            if (inst_sram_en) begin
                pc        <= next_pc;
                req_pend  <= 1'b1;
                buf_valid <= 1'b0;
            end else if (req_pend) begin
                req_pend  <= 1'b0;    // Decode stalled
                buf_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_pend && !inst_sram_en)
            inst_buf <= inst_sram_rdata;
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      if_to_id_valid,
    input  wire core_pkg::word_t     if_pc,
    input  wire core_pkg::word_t     if_inst,
    output logic                     id_allowin,
    output logic                     br_taken,
    output core_pkg::word_t          br_target,
    output core_pkg::reg_idx_t       rf_raddr1,
    output core_pkg::reg_idx_t       rf_raddr2,
    input  wire core_pkg::word_t     rf_rdata1,
    input  wire core_pkg::word_t     rf_rdata2,
    input  wire core_pkg::reg_idx_t  ex_dest,
    input  wire                      ex_gr_we,
    input  wire core_pkg::reg_idx_t  mem_dest,
    input  wire                      mem_gr_we,
    input  wire core_pkg::reg_idx_t  wb_dest,
    input  wire                      wb_gr_we,
    input  wire                      ex_allowin,
    output logic                     id_to_ex_valid,
    output core_pkg::word_t          id_pc,
    output core_pkg::op_t            id_op,
    output core_pkg::word_t          id_src1,
    output core_pkg::word_t          id_src2,
    output core_pkg::word_t          id_st_data,
    output core_pkg::reg_idx_t       id_dest,
    output logic                     id_gr_we
);
    import core_pkg::*;

    logic  id_valid;
    word_t inst;
    logic  op_known;
    word_t si12, ui20, offs;
    logic  use_r1, use_r2;
    logic  hit1, hit2;
    logic  ready_go;

    assign si12 = {{20{inst[21]}}, inst[21:10]};
    assign ui20 = {inst[24:5], 12'b0};
    assign offs = {{14{inst[25]}}, inst[25:10], 2'b00};

    always_comb begin
        op_known = 1'b1;
        id_op    = op_add;
        if (inst[31:15] == opc_add_w)
            id_op = op_add;
        else if (inst[31:15] == opc_sub_w)
            id_op = op_sub;
        else if (inst[31:22] == opc_addi_w)
            id_op = op_addi;
        else if (inst[31:25] == opc_lu12i_w)
            id_op = op_lu12i;
        else if (inst[31:22] == opc_ld_w)
            id_op = op_ld;
        else if (inst[31:22] == opc_st_w)
            id_op = op_st;
        else if (inst[31:26] == opc_beq)
            id_op = op_beq;
        else if (inst[31:26] == opc_bne)
            id_op = op_bne;
        else if (inst[31:5] == opc_rdcntvl_w)
            id_op = op_rdcnt;
        else
            op_known = 1'b0;
    end

    // Stores and branches read rd as second source
    assign rf_raddr1 = inst[9:5];
    assign rf_raddr2 = (id_op inside {op_st, op_beq, op_bne}) ? inst[4:0] : inst[14:10];
    assign use_r1    = !(id_op inside {op_lu12i, op_rdcnt});
    assign use_r2    = id_op inside {op_add, op_sub, op_st, op_beq, op_bne};

    // Wait until producer has left writeback
    assign hit1 = (rf_raddr1 != 5'd0) && ((ex_gr_we && ex_dest == rf_raddr1) ||
        (mem_gr_we && mem_dest == rf_raddr1) || (wb_gr_we && wb_dest == rf_raddr1));
    assign hit2 = (rf_raddr2 != 5'd0) && ((ex_gr_we && ex_dest == rf_raddr2) ||
        (mem_gr_we && mem_dest == rf_raddr2) || (wb_gr_we && wb_dest == rf_raddr2));
    assign ready_go = !((use_r1 && hit1) || (use_r2 && hit2));

    assign id_allowin     = ~id_valid | (ready_go & ex_allowin);
    assign id_to_ex_valid = id_valid & ready_go;

    assign br_target = id_pc + offs;
    assign br_taken  = id_valid & ready_go & ex_allowin &
        ((id_op == op_beq && rf_rdata1 == rf_rdata2) ||
         (id_op == op_bne && rf_rdata1 != rf_rdata2));

    assign id_src1    = (id_op == op_lu12i) ? '0 : rf_rdata1;
    assign id_src2    = (id_op inside {op_add, op_sub}) ? rf_rdata2
                      : (id_op == op_lu12i) ? ui20 : si12;
    assign id_st_data = rf_rdata2;
    assign id_dest    = inst[4:0];
    assign id_gr_we   = !(id_op inside {op_st, op_beq, op_bne});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            id_valid <= 1'b0;
        else if (id_allowin)
            id_valid <= if_to_id_valid;    // Bubble after a taken branch
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            id_pc <= if_pc;
            inst  <= if_inst;
        end
    end

    a_known_op: assert property (@(posedge clk) disable iff (!arst_n)
        id_valid |-> op_known);

endmodule

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      id_to_ex_valid,
    input  wire core_pkg::word_t     id_pc,
    input  wire core_pkg::op_t       id_op,
    input  wire core_pkg::word_t     id_src1,
    input  wire core_pkg::word_t     id_src2,
    input  wire core_pkg::word_t     id_st_data,
    input  wire core_pkg::reg_idx_t  id_dest,
    input  wire                      id_gr_we,
    output logic                     ex_allowin,
    output core_pkg::reg_idx_t       ex_dest,
    output logic                     ex_gr_we,
    output logic                     data_sram_en,
    output core_pkg::byte_en_t       data_sram_we,
    output core_pkg::word_t          data_sram_addr,
    output core_pkg::word_t          data_sram_wdata,
    input  wire                      mem_allowin,
    output logic                     ex_to_mem_valid,
    output core_pkg::word_t          ex_pc,
    output core_pkg::word_t          ex_result,
    output logic                     ex_is_load
);
    import core_pkg::*;

    logic        ex_valid;
    op_t         op;
    word_t       src1, src2, st_data;
    logic        gr_we;
    word_t       sum;
    logic        mem_access;
    logic [63:0] stable_cnt;    // Free-running since reset

    assign ex_allowin      = ~ex_valid | mem_allowin;
    assign ex_to_mem_valid = ex_valid;
    assign ex_gr_we        = ex_valid & gr_we;
    assign ex_is_load      = op == op_ld;

    assign sum       = src1 + src2;    // Also the load/store address
    assign ex_result = (op == op_sub) ? src1 - src2
                     : (op == op_rdcnt) ? stable_cnt[31:0] : sum;

    // Request goes out as the item moves to mem
    assign mem_access      = ex_valid & mem_allowin & (op == op_ld || op == op_st);
    assign data_sram_en    = mem_access;
    assign data_sram_we    = (mem_access && op == op_st) ? 4'hf : 4'h0;
    assign data_sram_addr  = sum;
    assign data_sram_wdata = st_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid   <= 1'b0;
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 64'd1;
            if (ex_allowin)
                ex_valid <= id_to_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_ex_valid && ex_allowin) begin
            ex_pc   <= id_pc;
            op      <= id_op;
            src1    <= id_src1;
            src2    <= id_src2;
            st_data <= id_st_data;
            ex_dest <= id_dest;
            gr_we   <= id_gr_we;
        end
    end

    a_data_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        data_sram_en |-> data_sram_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      ex_to_mem_valid,
    input  wire core_pkg::word_t     ex_pc,
    input  wire core_pkg::word_t     ex_result,
    input  wire                      ex_is_load,
    input  wire core_pkg::reg_idx_t  ex_dest,
    input  wire                      ex_gr_we,
    output logic                     mem_allowin,
    output core_pkg::reg_idx_t       mem_dest,
    output logic                     mem_gr_we,
    input  wire core_pkg::word_t     data_sram_rdata,
    output logic                     mem_to_wb_valid,
    output core_pkg::word_t          mem_pc,
    output core_pkg::word_t          mem_result,
    input  wire                      wb_allowin
);
    import core_pkg::*;

    logic  mem_valid;
    logic  is_load;
    logic  gr_we;
    word_t result;

    assign mem_allowin     = ~mem_valid | wb_allowin;
    assign mem_to_wb_valid = mem_valid;
    assign mem_gr_we       = mem_valid & gr_we;
    assign mem_result      = is_load ? data_sram_rdata : result;    // SRAM word lands here

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mem_valid <= 1'b0;
        else if (mem_allowin)
            mem_valid <= ex_to_mem_valid;
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            mem_pc   <= ex_pc;
            result   <= ex_result;
            is_load  <= ex_is_load;
            mem_dest <= ex_dest;
            gr_we    <= ex_gr_we;
        end
    end

endmodule

`default_nettype wire

// File: wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      mem_to_wb_valid,
    input  wire core_pkg::word_t     mem_pc,
    input  wire core_pkg::word_t     mem_result,
    input  wire core_pkg::reg_idx_t  mem_dest,
    input  wire                      mem_gr_we,
    output logic                     wb_allowin,
    output core_pkg::reg_idx_t       wb_dest,
    output logic                     wb_gr_we,
    output logic                     rf_we,
    output core_pkg::reg_idx_t       rf_waddr,
    output core_pkg::word_t          rf_wdata,
    output core_pkg::word_t          debug_wb_pc,
    output core_pkg::byte_en_t       debug_wb_rf_we,
    output core_pkg::reg_idx_t       debug_wb_rf_wnum,
    output core_pkg::word_t          debug_wb_rf_wdata
);
    import core_pkg::*;

    logic  wb_valid;
    logic  gr_we;
    word_t pc;
    word_t result;

    assign wb_allowin = 1'b1;    // Register write never waits
    assign wb_gr_we   = wb_valid & gr_we;
    assign rf_we      = wb_gr_we & (wb_dest != 5'd0);
    assign rf_waddr   = wb_dest;
    assign rf_wdata   = result;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};    // r0 writes stay silent
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else if (wb_allowin)
            wb_valid <= mem_to_wb_valid;
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            pc      <= mem_pc;
            result  <= mem_result;
            wb_dest <= mem_dest;
            gr_we   <= mem_gr_we;
        end
    end

endmodule

`default_nettype wire

// File: core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top (
    input  wire                       clk,
    input  wire                       arst_n,
    // Instruction SRAM
    output wire                       inst_sram_en,
    output wire core_pkg::byte_en_t   inst_sram_we,
    output wire core_pkg::word_t      inst_sram_addr,
    output wire core_pkg::word_t      inst_sram_wdata,
    input  wire core_pkg::word_t      inst_sram_rdata,
    // Data SRAM
    output wire                       data_sram_en,
    output wire core_pkg::byte_en_t   data_sram_we,
    output wire core_pkg::word_t      data_sram_addr,
    output wire core_pkg::word_t      data_sram_wdata,
    input  wire core_pkg::word_t      data_sram_rdata,
    // Retirement trace
    output wire core_pkg::word_t      debug_wb_pc,
    output wire core_pkg::byte_en_t   debug_wb_rf_we,
    output wire core_pkg::reg_idx_t   debug_wb_rf_wnum,
    output wire core_pkg::word_t      debug_wb_rf_wdata
);
    import core_pkg::*;

    // Handshake
    wire           id_allowin, ex_allowin, mem_allowin, wb_allowin;
    wire           if_to_id_valid, id_to_ex_valid, ex_to_mem_valid, mem_to_wb_valid;

    wire           br_taken;
    wire word_t    br_target;

    // Stage payloads
    wire word_t    if_pc, id_pc, ex_pc, mem_pc;
    wire word_t    if_inst;
    wire op_t      id_op;
    wire word_t    id_src1, id_src2, id_st_data;
    wire reg_idx_t id_dest;
    wire           id_gr_we;
    wire word_t    ex_result, mem_result;
    wire           ex_is_load;

    // Hazard feedback to decode
    wire reg_idx_t ex_dest, mem_dest, wb_dest;
    wire           ex_gr_we, mem_gr_we, wb_gr_we;

    wire reg_idx_t rf_raddr1, rf_raddr2, rf_waddr;
    wire word_t    rf_rdata1, rf_rdata2, rf_wdata;
    wire           rf_we;

    if_stage  i_if  (.*);
    id_stage  i_id  (.*);
    ex_stage  i_ex  (.*);
    mem_stage i_mem (.*);
    wb_stage  i_wb  (.*);

    regfile i_rf (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

`default_nettype wire

// File: tb_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int    imem_words     = 64;
    localparam int    dmem_words     = 256;
    localparam int    retire_timeout = 200;    // Cycles per retirement
    localparam word_t nop_inst       = 32'h0280_0000;    // addi.w r0, r0, 0

    logic     clk;
    logic     arst_n;
    logic     inst_sram_en;
    byte_en_t inst_sram_we;
    word_t    inst_sram_addr, inst_sram_wdata, inst_sram_rdata;
    logic     data_sram_en;
    byte_en_t data_sram_we;
    word_t    data_sram_addr, data_sram_wdata, data_sram_rdata;
    word_t    debug_wb_pc;
    byte_en_t debug_wb_rf_we;
    reg_idx_t debug_wb_rf_wnum;
    word_t    debug_wb_rf_wdata;

    word_t    imem [0:imem_words-1];
    word_t    dmem [0:dmem_words-1];
    word_t    sreg [0:31];    // Shadow register file
    word_t    sdmem [0:dmem_words-1];
    word_t    exp_pc [$];
    reg_idx_t exp_num [$];
    word_t    exp_val [$];
    logic     exp_cnt [$];
    word_t    cnt_seen [$];
    int       prog_len;

    core_top i_dut (
        .clk               (clk),
        .arst_n            (arst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic word_t fetch_word(input word_t addr);
        word_t off;
        off = addr - reset_pc;
        if (addr < reset_pc || off >= imem_words * 4)
            return nop_inst;
        return imem[off[31:2]];
    endfunction

    function automatic word_t enc_r3(input logic [16:0] opc, input reg_idx_t rk,
                                     input reg_idx_t rj, input reg_idx_t rd);
        return {opc, rk, rj, rd};
    endfunction

    function automatic word_t enc_i12(input logic [9:0] opc, input logic [11:0] imm,
                                      input reg_idx_t rj, input reg_idx_t rd);
        return {opc, imm, rj, rd};
    endfunction

    function automatic word_t enc_br(input logic [5:0] opc, input logic [15:0] offs,
                                     input reg_idx_t rj, input reg_idx_t rd);
        return {opc, offs, rj, rd};    // offs counts words
    endfunction

    task automatic put_inst(input word_t inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    // One instruction on the shadow state
    function automatic void iss_step(input word_t pc, input word_t inst, output word_t npc,
                                     output logic wr, output reg_idx_t wnum, output word_t val,
                                     output logic is_cnt, output logic known);
        word_t rj_val, rk_val, rd_val, imm12, addr;
        rj_val = sreg[inst[9:5]];
        rk_val = sreg[inst[14:10]];
        rd_val = sreg[inst[4:0]];
        imm12  = {{20{inst[21]}}, inst[21:10]};
        addr   = rj_val + imm12;
        npc    = pc + 32'd4;
        wr     = 1'b1;
        wnum   = inst[4:0];
        val    = '0;
        is_cnt = 1'b0;
        known  = 1'b1;
        if (inst[31:15] == opc_add_w)
            val = rj_val + rk_val;
        else if (inst[31:15] == opc_sub_w)
            val = rj_val - rk_val;
        else if (inst[31:22] == opc_addi_w)
            val = rj_val + imm12;
        else if (inst[31:25] == opc_lu12i_w)
            val = {inst[24:5], 12'h000};
        else if (inst[31:22] == opc_ld_w)
            val = sdmem[addr[9:2]];
        else if (inst[31:22] == opc_st_w) begin
            wr = 1'b0;
            sdmem[addr[9:2]] = rd_val;
        end else if (inst[31:26] == opc_beq || inst[31:26] == opc_bne) begin
            wr = 1'b0;
            if ((rj_val == rd_val) == (inst[31:26] == opc_beq))
                npc = pc + {{14{inst[25]}}, inst[25:10], 2'b00};
        end else if (inst[31:5] == opc_rdcntvl_w)
            is_cnt = 1'b1;    // Value depends on timing
        else
            known = 1'b0;
        if (wnum == 5'd0)
            wr = 1'b0;
        if (wr)
            sreg[wnum] = val;
    endfunction

    always @(posedge clk) begin : inst_sram_model
        logic     en;
        byte_en_t we;
        word_t    addr;
        en   = inst_sram_en;
        we   = inst_sram_we;
        addr = inst_sram_addr;
        check("inst_sram_we", we, '0);    // Never written
        #1;
        if (en)
            inst_sram_rdata = fetch_word(addr);
    end

    always @(posedge clk) begin : data_sram_model
        logic     en;
        byte_en_t we;
        word_t    addr, wdata;
        en    = data_sram_en;
        we    = data_sram_we;
        addr  = data_sram_addr;
        wdata = data_sram_wdata;
        #1;
        if (en) begin
            data_sram_rdata = dmem[addr[9:2]];
            if (we == 4'hf)
                dmem[addr[9:2]] = wdata;
        end
    end

    initial begin : run
        word_t       pc, npc, val, st_addr, ld_addr, rnd;
        logic        wr, is_cnt, known, halted;
        reg_idx_t    wnum;
        int          cycles;
        arst_n          = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        rnd = $urandom(32'h6e9f_4bec);
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i]  = $urandom;
            sdmem[i] = dmem[i];
        end
        for (int i = 0; i < imem_words; i++)
            imem[i] = nop_inst;
        for (int i = 0; i < 32; i++)
            sreg[i] = '0;
        st_addr  = ($urandom % 128) * 4;    // Lower half of data memory
        ld_addr  = 32'h200 + ($urandom % 128) * 4;
        rnd      = $urandom;
        prog_len = 0;

        put_inst({opc_lu12i_w, 20'h80000, 5'd1});
        put_inst(enc_i12(opc_addi_w, 12'hfff, 5'd1, 5'd2));    // Wraps to 7fffffff
        put_inst(enc_r3(opc_add_w, 5'd2, 5'd2, 5'd3));
        put_inst(enc_r3(opc_sub_w, 5'd1, 5'd0, 5'd4));
        put_inst(enc_i12(opc_addi_w, 12'h800, 5'd0, 5'd5));
        put_inst(enc_r3(opc_add_w, 5'd3, 5'd5, 5'd6));
        put_inst(enc_r3(opc_sub_w, 5'd6, 5'd5, 5'd7));
        put_inst(enc_r3(opc_add_w, 5'd2, 5'd1, 5'd0));    // r0 target
        put_inst(enc_i12(opc_addi_w, st_addr[11:0], 5'd0, 5'd8));
        put_inst({opc_lu12i_w, rnd[31:12], 5'd9});
        put_inst(enc_i12(opc_addi_w, rnd[11:0], 5'd9, 5'd9));
        put_inst(enc_i12(opc_st_w, 12'h000, 5'd8, 5'd9));
        put_inst(enc_i12(opc_ld_w, 12'h000, 5'd8, 5'd10));
        put_inst(enc_i12(opc_ld_w, ld_addr[11:0], 5'd0, 5'd11));
        put_inst({opc_rdcntvl_w, 5'd13});
        put_inst(enc_br(opc_beq, 16'd2, 5'd10, 5'd9));    // Taken
        put_inst(enc_i12(opc_addi_w, 12'h001, 5'd0, 5'd14));
        put_inst(enc_br(opc_bne, 16'd2, 5'd10, 5'd9));
        put_inst(enc_i12(opc_addi_w, 12'h007, 5'd0, 5'd15));
        put_inst(enc_br(opc_bne, 16'd2, 5'd15, 5'd0));    // Taken
        put_inst(enc_i12(opc_addi_w, 12'h009, 5'd0, 5'd16));
        put_inst(enc_br(opc_beq, 16'd2, 5'd15, 5'd0));
        put_inst(enc_r3(opc_add_w, 5'd5, 5'd15, 5'd17));
        put_inst({opc_rdcntvl_w, 5'd18});
        put_inst(enc_r3(opc_sub_w, 5'd1, 5'd17, 5'd19));
        put_inst(enc_br(opc_beq, 16'd0, 5'd0, 5'd0));    // Self-branch

        pc     = reset_pc;
        halted = 1'b0;
        for (int n = 0; n < 500 && !halted; n++) begin
            iss_step(pc, fetch_word(pc), npc, wr, wnum, val, is_cnt, known);
            if (!known) begin
                $display("Reference model found an undefined instruction at pc %h", pc);
                $display("Simulation failed");
                $fatal(1);
            end
            if (wr) begin
                exp_pc.push_back(pc);
                exp_num.push_back(wnum);
                exp_val.push_back(val);
                exp_cnt.push_back(is_cnt);
            end
            halted = (npc == pc);
            pc     = npc;
        end
        if (!halted) begin
            $display("Reference model never reached the final self-branch");
            $display("Simulation failed");
            $fatal(1);
        end

        repeat (5) begin
            @(posedge clk);
            #1;
            check("inst_sram_en", inst_sram_en, '0);
            check("data_sram_en", data_sram_en, '0);
            check("data_sram_we", data_sram_we, '0);
            check("debug_wb_rf_we", debug_wb_rf_we, '0);
        end
        arst_n = 1'b1;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!inst_sram_en && cycles < 10);
        if (!inst_sram_en) begin
            $display("Core issued no instruction fetch after reset was released");
            $display("Simulation failed");
            $fatal(1);
        end
        check("inst_sram_addr", inst_sram_addr, reset_pc);

        for (int k = 0; k < exp_pc.size(); k++) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (k == 0)
                    check("data_sram_we", data_sram_we, '0);
            end while (debug_wb_rf_we == 4'h0 && cycles < retire_timeout);
            if (debug_wb_rf_we == 4'h0) begin
                $display("Core stopped retiring: write %0d of %0d never appeared",
                         k + 1, exp_pc.size());
                $display("Simulation failed");
                $fatal(1);
            end
            check("debug_wb_rf_we", debug_wb_rf_we, 4'hf);
            check("debug_wb_pc", debug_wb_pc, exp_pc[k]);
            check("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_num[k]);
            if (exp_cnt[k])
                cnt_seen.push_back(debug_wb_rf_wdata);
            else
                check("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[k]);
        end

        // Only the self-branch runs from here on
        repeat (20) begin
            @(negedge clk);
            check("debug_wb_rf_we", debug_wb_rf_we, '0);
        end
        if (cnt_seen[1] <= cnt_seen[0]) begin
            $display("rdcntvl.w results not strictly increasing: %h then %h",
                     cnt_seen[0], cnt_seen[1]);
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
core_pkg.sv
regfile.sv
if_stage.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
wb_stage.sv
core_top.sv
tb_core.sv
